//--- all.f
+incdir+.
exe_pkg.sv
op_decode.sv
alu_core.sv
seq_mul.sv
exe_unit.sv
result_queue.sv
exe_top.sv
tb_exe.sv

//--- Bender.yml
package:
  name: exe_stage

sources:
  - exe_pkg.sv
  - op_decode.sv
  - alu_core.sv
  - seq_mul.sv
  - exe_unit.sv
  - result_queue.sv
  - exe_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exe.sv

//--- exe_ref_model.svh
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

function automatic xlen_t sign_extend_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

// RV64 integer op picked by funct3 with alt for sub and sra
function automatic xlen_t alu_value(input logic [2:0] f3, input logic alt, input logic word,
                                    input xlen_t a, input xlen_t b);
    logic [5:0]  sh;
    logic [31:0] lo;
    xlen_t       r;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    case (f3)
        3'b000: r = alt ? a - b : a + b;
        3'b001: r = a << sh;
        3'b010: r = {63'd0, $signed(a) < $signed(b)};
        3'b011: r = {63'd0, a < b};
        3'b100: r = a ^ b;
        3'b101: begin
            if (word) begin
                if (alt) begin
                    lo = $signed(a[31:0]) >>> sh;
                end else begin
                    lo = a[31:0] >> sh;
                end
                r = {32'd0, lo};
            end else if (alt) begin
                r = $signed(a) >>> sh;
            end else begin
                r = a >> sh;
            end
        end
        3'b110: r = a | b;
        default: r = a & b;
    endcase
    return word ? sign_extend_word(r[31:0]) : r;
endfunction

function automatic xlen_t mul_value(input logic word, input xlen_t a, input xlen_t b);
    xlen_t prod;
    // low 64 bits of the product
    prod = a * b;
    return word ? sign_extend_word(prod[31:0]) : prod;
endfunction

function automatic exe_res_t expected_result(input iss_pkt_t p);
    exe_res_t e;
    e.tag = p.tag;
    case (p.kind)
        ALU_REG: begin
            if (p.is_mext) begin
                e.value = mul_value(p.is_word, p.rs1, p.rs2);
            end else begin
                e.value = alu_value(p.funct3, p.funct7_5, p.is_word, p.rs1, p.rs2);
            end
        end
        // addi never turns into sub
        ALU_IMM: e.value = alu_value(p.funct3, p.funct7_5 && (p.funct3 == 3'b101),
                                     p.is_word, p.rs1, p.imm);
        LUI:     e.value = p.imm;
        AUIPC:   e.value = p.pc + p.imm;
        default: e.value = p.pc + 64'd4;
    endcase
    return e;
endfunction

`endif

//--- tb_exe.sv
`default_nettype none

module tb_exe import exe_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    `include "exe_ref_model.svh"

    localparam int MUL_BITS        = 4;
    localparam int RQ_DEPTH        = 4;
    localparam int RES_CREDITS     = 2;
    localparam int N_SINGLE        = 80;
    localparam int N_UPPER         = 30;
    localparam int N_MIX           = 60;
    localparam int N_STARVE        = 20;
    localparam int N_FLUSH         = 12;
    localparam int STARVE_CYCLES   = 120;
    localparam int N_OPS           = N_SINGLE + N_UPPER + N_MIX + N_STARVE + 3 * N_FLUSH;
    localparam int WATCHDOG_CYCLES = N_OPS * (64 / MUL_BITS + 10) + STARVE_CYCLES;

    logic     clk;
    logic     rst_n;
    logic     flush;
    logic     in_valid;
    iss_pkt_t in_pkt;
    logic     in_credit;
    logic     res_valid;
    exe_res_t res;
    logic     res_credit;

    int       seed = 32'h406cd00d;
    string    phase = "reset";
    logic     starve = 1'b0;
    logic     give_credit;
    exe_res_t exp_q[$];
    exe_res_t exp_head = '0;
    int       exp_cnt = 0;
    int       issuer_credits;
    int       consumer_credits;
    int       owed;
    int       in_valid_count;
    int       in_credit_count;
    int       received;
    int       issued = 0;
    int       flushed = 0;
    int       value_errors = 0;
    int       protocol_errors = 0;

    exe_top #(
        .MUL_BITS    (MUL_BITS),
        .RQ_DEPTH    (RQ_DEPTH),
        .RES_CREDITS (RES_CREDITS)
    ) exe_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // credit counts on both ports as the issuer and consumer see them
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issuer_credits   <= 1;
            consumer_credits <= RES_CREDITS;
            owed             <= 0;
            in_valid_count   <= 0;
            in_credit_count  <= 0;
            received         <= 0;
        end else begin
            issuer_credits   <= issuer_credits + int'(in_credit) - int'(in_valid);
            consumer_credits <= consumer_credits + int'(res_credit) - int'(res_valid);
            owed             <= owed + int'(res_valid) - int'(res_credit);
            in_valid_count   <= in_valid_count + int'(in_valid);
            in_credit_count  <= in_credit_count + int'(in_credit);
            received         <= received + int'(res_valid);
        end
    end

    task automatic refresh_head();
        exp_cnt  = exp_q.size();
        exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
    endtask

    always @(posedge clk) begin
        if (rst_n && res_valid && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    result_value: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && exp_cnt != 0 |-> res == exp_head)
    else begin
        value_errors++;
        $display("Error result_value [%s] expected %h actual %h",
                 phase, $sampled(exp_head), $sampled(res));
    end

    result_expected: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> exp_cnt != 0)
    else begin
        protocol_errors++;
        $display("a result arrived while none was outstanding [%s]", phase);
    end

    consumer_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> consumer_credits != 0)
    else begin
        protocol_errors++;
        $display("res_valid fired while the consumer held no credit [%s]", phase);
    end

    issuer_credit: assert property (@(posedge clk) disable iff (!rst_n)
        in_credit |-> issuer_credits == 0)
    else begin
        protocol_errors++;
        $display("in_credit returned while the issuer already held its credit [%s]", phase);
    end

    // consumer hands back one credit per result taken after random gaps
    initial begin
        res_credit = 1'b0;
        forever begin
            @(posedge clk);
            give_credit = (($random(seed) & 3) != 0) && !starve;
            #1;
            res_credit = give_credit && owed > 0;
        end
    end

    function automatic iss_pkt_t make_pkt(input op_kind_e kind, input logic mext);
        iss_pkt_t    p;
        logic [31:0] r;
        p.tag      = '0;
        p.kind     = kind;
        p.funct3   = 3'($random(seed));
        p.funct7_5 = 1'($random(seed));
        p.is_mext  = mext;
        p.pc       = {$random(seed), $random(seed)};
        p.rs1      = {$random(seed), $random(seed)};
        p.rs2      = {$random(seed), $random(seed)};
        r          = $random(seed);
        p.imm      = (kind == ALU_IMM) ? {{52{r[11]}}, r[11:0]} : {{32{r[31]}}, r[31:12], 12'd0};
        p.is_word  = 1'($random(seed)) &&
                     (mext || p.funct3 == 3'b000 || p.funct3 == 3'b001 || p.funct3 == 3'b101);
        // shifts by 63
        if (($random(seed) & 3) == 0) begin
            p.rs2[5:0] = 6'h3f;
            p.imm[5:0] = 6'h3f;
        end
        // equal compare operands
        if (($random(seed) & 7) == 0) begin
            p.rs2 = p.rs1;
        end
        return p;
    endfunction

    function automatic iss_pkt_t mixed_pkt(input logic allow_mul);
        op_kind_e kind;
        kind = 1'($random(seed)) ? ALU_REG : ALU_IMM;
        return make_pkt(kind, allow_mul && kind == ALU_REG && 1'($random(seed)));
    endfunction

    function automatic iss_pkt_t upper_pkt();
        op_kind_e kind;
        kind = op_kind_e'(3'd2 + 3'(($random(seed) & 32'h7fffffff) % 3));
        return make_pkt(kind, 1'b0);
    endfunction

    // runs from 1 ns after an edge until 1 ns after the capture edge
    task automatic issue_op(input iss_pkt_t pkt);
        iss_pkt_t p;
        p     = pkt;
        p.tag = tag_t'(issued);
        while (issuer_credits == 0) begin
            @(posedge clk);
            #1;
        end
        in_pkt   = p;
        in_valid = 1'b1;
        exp_q.push_back(expected_result(p));
        refresh_head();
        issued++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic flush_mul(input iss_pkt_t pkt, input int wait_cycles);
        issue_op(pkt);
        repeat (wait_cycles) begin
            @(posedge clk);
            #1;
        end
        // credit still out means the multiply is still in the slot
        if (issuer_credits == 0) begin
            flush = 1'b1;
            void'(exp_q.pop_back());
            refresh_head();
            flushed++;
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("watchdog expired before all results arrived [%s]", phase);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_pkt   = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!in_credit && !res_valid) else begin
            protocol_errors++;
            $display("in_credit or res_valid was high right after reset");
        end

        phase = "single_cycle";
        repeat (N_SINGLE) issue_op(mixed_pkt(1'b0));

        phase = "upper_and_link";
        repeat (N_UPPER) issue_op(upper_pkt());

        phase = "mul_mix";
        repeat (N_MIX) issue_op(mixed_pkt(1'b1));

        phase = "starvation";
        starve = 1'b1;
        fork
            begin
                repeat (STARVE_CYCLES) @(posedge clk);
                #1;
                starve = 1'b0;
            end
        join_none
        repeat (N_STARVE) issue_op(mixed_pkt(1'b1));

        phase = "flush";
        repeat (N_FLUSH) begin
            flush_mul(make_pkt(ALU_REG, 1'b1), $random(seed) & 7);
            issue_op(mixed_pkt(1'b0));
            issue_op(mixed_pkt(1'b1));
        end

        phase = "drain";
        while (exp_cnt != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        assert (in_valid_count == in_credit_count) else begin
            protocol_errors++;
            $display("Error credit_return expected %0d actual %0d",
                     in_valid_count, in_credit_count);
        end
        assert (received == issued - flushed) else begin
            value_errors++;
            $display("Error result_count expected %0d actual %0d", issued - flushed, received);
        end

        $display("error counts: %0d value, %0d protocol (%0d issued, %0d flushed, %0d received)",
                 value_errors, protocol_errors, issued, flushed, received);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exe_top.sv
`default_nettype none

module exe_top import exe_pkg::*; #(
    parameter int MUL_BITS    = 4,
    parameter int RQ_DEPTH    = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  iss_pkt_t in_pkt,
    output logic     in_credit,
    output logic     res_valid,
    output exe_res_t res,
    input  logic     res_credit
);

    exe_req_t dec_req;
    logic     rq_push;
    exe_res_t rq_data;
    logic     rq_full;

    op_decode op_decode_inst (
        .in_pkt (in_pkt),
        .req    (dec_req)
    );

    exe_unit #(
        .MUL_BITS (MUL_BITS)
    ) exe_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (dec_req),
        .flush     (flush),
        .in_credit (in_credit),
        .rq_push   (rq_push),
        .rq_data   (rq_data),
        .rq_full   (rq_full)
    );

    result_queue #(
        .RQ_DEPTH    (RQ_DEPTH),
        .RES_CREDITS (RES_CREDITS)
    ) result_queue_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (rq_push),
        .data       (rq_data),
        .full       (rq_full),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

`default_nettype wire

//--- result_queue.sv
`default_nettype none

module result_queue import exe_pkg::*; #(
    parameter int RQ_DEPTH    = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  exe_res_t data,
    output logic     full,
    input  logic     res_credit,
    output logic     res_valid,
    output exe_res_t res
);

    localparam int PTR_W = (RQ_DEPTH > 1) ? $clog2(RQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(RQ_DEPTH + 1);
    localparam int CR_W  = $clog2(RES_CREDITS + 1);

    exe_res_t         mem [RQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CR_W-1:0]  credits;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(RQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(RQ_DEPTH));
    assign pop       = (count != '0) && (credits != '0);
    assign res_valid = pop;
    assign res       = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CR_W'(RES_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // each send spends one, each returned pulse adds one
            case ({res_credit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data;
        end
    end

endmodule

`default_nettype wire

//--- exe_unit.sv
`default_nettype none

module exe_unit import exe_pkg::*; #(
    parameter int MUL_BITS = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  exe_req_t req,
    input  logic     flush,
    output logic     in_credit,
    output logic     rq_push,
    output exe_res_t rq_data,
    input  logic     rq_full
);

    exe_state_e state_q;
    logic       busy_q;
    tag_t       tag_q;
    logic       word_q;
    xlen_t      val_q;
    xlen_t      alu_y;
    logic       capture;
    logic       res_pending;
    logic       mul_start;
    logic       mul_kill;
    logic       mul_done;
    xlen_t      mul_prod;

    alu_core alu_core_inst (
        .op      (req.alu_op),
        .is_word (req.is_word),
        .a       (req.a),
        .b       (req.b),
        .y       (alu_y)
    );

    seq_mul #(
        .MUL_BITS (MUL_BITS)
    ) seq_mul_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mul_start),
        .kill  (mul_kill),
        .a     (req.a),
        .b     (req.b),
        .done  (mul_done),
        .prod  (mul_prod)
    );

    // an op arriving together with flush dies on entry
    assign capture     = in_valid && !flush;
    assign mul_start   = capture && (req.alu_op == OP_MUL);
    assign mul_kill    = flush;
    assign res_pending = busy_q && (state_q == S_IDLE);
    assign rq_push     = res_pending && !rq_full && !flush;
    assign in_credit   = flush ? (busy_q || in_valid) : rq_push;
    assign rq_data     = '{tag: tag_q, value: val_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            busy_q  <= 1'b0;
        end else if (flush) begin
            state_q <= S_IDLE;
            busy_q  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (rq_push) begin
                        busy_q <= 1'b0;
                    end
                    if (capture) begin
                        busy_q <= 1'b1;
                        if (mul_start) begin
                            state_q <= S_MUL;
                        end
                    end
                end
                S_MUL: begin
                    if (mul_done) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            tag_q  <= req.tag;
            word_q <= req.is_word;
            val_q  <= alu_y;
        end else if (state_q == S_MUL && mul_done) begin
            val_q <= word_q ? sext32(mul_prod[31:0]) : mul_prod;
        end
    end

endmodule

`default_nettype wire

//--- seq_mul.sv
`default_nettype none

module seq_mul import exe_pkg::*; #(
    parameter int MUL_BITS = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  kill,
    input  xlen_t a,
    input  xlen_t b,
    output logic  done,
    output xlen_t prod
);

    localparam int STEPS = XLEN / MUL_BITS;
    localparam int CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] step;
    logic             last;
    logic             active;
    xlen_t            mcand;
    xlen_t            mplier;
    xlen_t            acc;
    xlen_t            op_a;
    xlen_t            op_b;
    xlen_t            acc_in;
    xlen_t            acc_nxt;

    // the first step runs in the start cycle, straight from the operands
    assign op_a    = start ? a : mcand;
    assign op_b    = start ? b : mplier;
    assign acc_in  = start ? '0 : acc;
    assign step    = start ? '0 : cnt;
    assign last    = (step == CNT_W'(STEPS - 1));
    assign active  = start || busy;
    assign acc_nxt = acc_in + op_a * xlen_t'(op_b[MUL_BITS-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else if (kill) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (active) begin
            busy <= !last;
            cnt  <= step + 1'b1;
            done <= last;
        end else begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            mcand  <= op_a << MUL_BITS;
            mplier <= op_b >> MUL_BITS;
            acc    <= acc_nxt;
        end
    end

    // low 64 bits only
    assign prod = acc;

endmodule

`default_nettype wire

//--- alu_core.sv
`default_nettype none

module alu_core import exe_pkg::*; (
    input  alu_op_e op,
    input  logic    is_word,
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   y
);

    logic [5:0]  shamt;
    logic [31:0] srl_w;
    logic [31:0] sra_w;
    xlen_t       srl_d;
    xlen_t       sra_d;
    xlen_t       r;

    // word shifts only use 5 bits of the amount
    assign shamt = is_word ? {1'b0, b[4:0]} : b[5:0];

    assign srl_w = a[31:0] >> shamt;
    assign sra_w = $signed(a[31:0]) >>> shamt;
    assign srl_d = a >> shamt;
    assign sra_d = $signed(a) >>> shamt;

    always_comb begin
        case (op)
            OP_ADD:    r = a + b;
            OP_SUB:    r = a - b;
            OP_SLL:    r = a << shamt;
            OP_SLT:    r = {63'd0, $signed(a) < $signed(b)};
            OP_SLTU:   r = {63'd0, a < b};
            OP_XOR:    r = a ^ b;
            OP_SRL: begin
                if (is_word) begin
                    r = {32'd0, srl_w};
                end else begin
                    r = srl_d;
                end
            end
            OP_SRA: begin
                if (is_word) begin
                    r = {32'd0, sra_w};
                end else begin
                    r = sra_d;
                end
            end
            OP_OR:     r = a | b;
            OP_AND:    r = a & b;
            OP_PASS_B: r = b;
            // multiply goes through seq_mul
            default:   r = '0;
        endcase
    end

    assign y = is_word ? sext32(r[31:0]) : r;

endmodule

`default_nettype wire

//--- op_decode.sv
`default_nettype none

module op_decode import exe_pkg::*; (
    input  iss_pkt_t in_pkt,
    output exe_req_t req
);

    // register and immediate forms share this table
    function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? OP_SUB : OP_ADD;
            3'b001:  op = OP_SLL;
            3'b010:  op = OP_SLT;
            3'b011:  op = OP_SLTU;
            3'b100:  op = OP_XOR;
            3'b101:  op = alt ? OP_SRA : OP_SRL;
            3'b110:  op = OP_OR;
            default: op = OP_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        req.tag     = in_pkt.tag;
        req.is_word = in_pkt.is_word;
        req.a       = in_pkt.rs1;
        req.b       = in_pkt.rs2;
        req.alu_op  = OP_ADD;
        case (in_pkt.kind)
            ALU_REG: begin
                req.alu_op = in_pkt.is_mext ? OP_MUL : f3_op(in_pkt.funct3, in_pkt.funct7_5);
            end
            ALU_IMM: begin
                req.b = in_pkt.imm;
                // addi has no sub form, bit 30 is part of the immediate
                if (in_pkt.funct3 != 3'b000) begin
                    req.alu_op = f3_op(in_pkt.funct3, in_pkt.funct7_5);
                end
            end
            LUI: begin
                req.b       = in_pkt.imm;
                req.alu_op  = OP_PASS_B;
                req.is_word = 1'b0;
            end
            AUIPC: begin
                req.a       = in_pkt.pc;
                req.b       = in_pkt.imm;
                req.is_word = 1'b0;
            end
            JUMP_LINK: begin
                req.a       = in_pkt.pc;
                req.b       = xlen_t'(4);
                req.is_word = 1'b0;
            end
            default: begin
                req.alu_op = OP_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- exe_pkg.sv
`default_nettype none

package exe_pkg;

    localparam int XLEN  = 64;
    localparam int TAG_W = 4;

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [2:0] {
        ALU_REG,
        ALU_IMM,
        LUI,
        AUIPC,
        JUMP_LINK
    } op_kind_e;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_PASS_B,
        OP_MUL
    } alu_op_e;

    // funct7_5 picks sub/sra, is_mext marks the M extension
    typedef struct packed {
        tag_t       tag;
        op_kind_e   kind;
        logic [2:0] funct3;
        logic       funct7_5;
        logic       is_mext;
        logic       is_word;
        xlen_t      pc;
        xlen_t      rs1;
        xlen_t      rs2;
        xlen_t      imm;
    } iss_pkt_t;

    typedef struct packed {
        tag_t    tag;
        alu_op_e alu_op;
        logic    is_word;
        xlen_t   a;
        xlen_t   b;
    } exe_req_t;

    typedef struct packed {
        tag_t  tag;
        xlen_t value;
    } exe_res_t;

    typedef enum logic {
        S_IDLE,
        S_MUL
    } exe_state_e;

    // RV64 word forms keep bit 31 as the sign
    function automatic xlen_t sext32(input logic [31:0] w);
        return {{(XLEN - 32){w[31]}}, w};
    endfunction

endpackage

`default_nettype wire
